//--- build.f
rtl/vec_pkg.sv
rtl/vec_stage_if.sv
rtl/vec_compare.sv
rtl/vec_select.sv
rtl/result_queue.sv
rtl/vec_minmax_top.sv
tb/vec_minmax_props.sv
tb/tb_vec_minmax.sv

//--- run.sh
#!/bin/sh
# compile with Verilator and run the testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f build.f \
    --top-module tb_vec_minmax \
    -Mdir obj_dir \
    -o sim_vec_minmax
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

sim_output=$(./obj_dir/sim_vec_minmax 2>&1)
sim_status=$?
printf '%s\n' "$sim_output"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "Everything OK"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

//--- tb/tb_vec_minmax.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vec_minmax;

    localparam int DEPTH           = vec_pkg::DEFAULT_FIFO_DEPTH;
    localparam int CLK_PERIOD      = 10;
    localparam int N_DIRECTED      = 32;
    localparam int N_SPECIAL       = 3;
    localparam int N_MIXED         = 120;
    localparam int TOTAL_ITEMS     = DEPTH + 3 * (N_DIRECTED + N_SPECIAL) + N_MIXED;
    localparam int WATCHDOG_CYCLES = TOTAL_ITEMS * 40 + 300;

    localparam vec_pkg::float_t POS_ZERO     = 32'h0000_0000;
    localparam vec_pkg::float_t NEG_ZERO     = 32'h8000_0000;
    localparam vec_pkg::float_t ONE          = 32'h3f80_0000;
    localparam vec_pkg::float_t NEG_ONE      = 32'hbf80_0000;
    localparam vec_pkg::float_t TWO          = 32'h4000_0000;
    localparam vec_pkg::float_t NEG_TWO_HALF = 32'hc020_0000;

    logic            clk_in = 1'b0;
    logic            rst_in;
    logic            in_valid;
    vec_pkg::op_t    in_op;
    vec_pkg::float_t in_a_x;
    vec_pkg::float_t in_a_y;
    vec_pkg::float_t in_a_z;
    vec_pkg::float_t in_b_x;
    vec_pkg::float_t in_b_y;
    vec_pkg::float_t in_b_z;
    logic            in_credit;
    logic            out_credit;
    logic            out_valid;
    vec_pkg::float_t out_x;
    vec_pkg::float_t out_y;
    vec_pkg::float_t out_z;

    integer      seed             = 10;
    logic [95:0] sb [$];
    int          credits_spent    = 0;
    int          credits_returned = 0;
    int          outputs_seen     = 0;
    int          manual_credits   = 0;
    int          credits_given    = 0;
    logic        credit_random    = 1'b0;

    vec_minmax_top #(
        .FIFO_DEPTH (DEPTH)
    ) dut_i (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_a_x     (in_a_x),
        .in_a_y     (in_a_y),
        .in_a_z     (in_a_z),
        .in_b_x     (in_b_x),
        .in_b_y     (in_b_y),
        .in_b_z     (in_b_z),
        .in_credit  (in_credit),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_x      (out_x),
        .out_y      (out_y),
        .out_z      (out_z)
    );

    always #5 clk_in = ~clk_in;

    task automatic report_failure(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("Something failed");
        $fatal(1, "stopping at first error");
    endtask

    // map to a signed key so that -0 and +0 land on the same value
    function automatic logic signed [32:0] order_key(input vec_pkg::float_t f);
        logic signed [32:0] mag;
        mag = $signed({2'b00, f[30:0]});
        return f[31] ? -mag : mag;
    endfunction

    function automatic logic is_less(input vec_pkg::float_t a, input vec_pkg::float_t b);
        return order_key(a) < order_key(b);
    endfunction

    function automatic logic [95:0] model_result(input vec_pkg::op_t op,
                                                 input logic [95:0] a,
                                                 input logic [95:0] b);
        vec_pkg::float_t ax;
        vec_pkg::float_t ay;
        vec_pkg::float_t az;
        vec_pkg::float_t pick;
        logic            c0;
        logic            c1;
        logic            c2;
        ax = a[95:64];
        ay = a[63:32];
        az = a[31:0];
        if (op == vec_pkg::OP_PMIN) begin
            return {is_less(ax, b[95:64]) ? ax : b[95:64],
                    is_less(ay, b[63:32]) ? ay : b[63:32],
                    is_less(az, b[31:0])  ? az : b[31:0]};
        end
        if (op == vec_pkg::OP_MAX) begin
            c0 = is_less(ay, ax);
            c1 = is_less(ay, az);
            c2 = is_less(ax, az);
        end else begin
            c0 = is_less(ax, ay);
            c1 = is_less(az, ay);
            c2 = is_less(az, ax);
        end
        pick = (c1 && c2) ? az : (c0 ? ax : ay);
        return {pick, 64'd0};
    endfunction

    // zeros and a few repeated values make ties common
    function automatic vec_pkg::float_t rand_float();
        int              pick;
        int              r;
        logic [7:0]      exp_bits;
        vec_pkg::float_t f;
        pick = $random(seed) & 7;
        r    = $random(seed);
        case (pick)
            0:       f = POS_ZERO;
            1:       f = NEG_ZERO;
            2:       f = (r & 1) ? ONE : NEG_ONE;
            3:       f = (r & 1) ? TWO : NEG_TWO_HALF;
            default: begin
                // exponent below 255 keeps out NaN and infinity
                exp_bits = 8'($unsigned(r) % 255);
                f = {r[31], exp_bits, 23'($random(seed))};
            end
        endcase
        return f;
    endfunction

    function automatic logic [95:0] rand_vec();
        vec_pkg::float_t x;
        vec_pkg::float_t y;
        vec_pkg::float_t z;
        int              tie;
        x   = rand_float();
        y   = rand_float();
        z   = rand_float();
        tie = $random(seed) & 7;
        if (tie == 0) begin
            y = x;
        end else if (tie == 1) begin
            z = y;
        end else if (tie == 2) begin
            z = x;
        end
        return {x, y, z};
    endfunction

    function automatic int available_credits();
        return DEPTH + credits_returned - credits_spent;
    endfunction

    task automatic next_cycle();
        @(posedge clk_in);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic send_item(input vec_pkg::op_t op, input logic [95:0] a,
                             input logic [95:0] b);
        // stall while upstream holds no credit
        while (available_credits() == 0) begin
            in_valid = 1'b0;
            next_cycle();
        end
        in_valid = 1'b1;
        in_op    = op;
        in_a_x   = a[95:64];
        in_a_y   = a[63:32];
        in_a_z   = a[31:0];
        in_b_x   = b[95:64];
        in_b_y   = b[63:32];
        in_b_z   = b[31:0];
        credits_spent = credits_spent + 1;
        sb.push_back(model_result(op, a, b));
        next_cycle();
        in_valid = 1'b0;
    endtask

    task automatic run_op(input vec_pkg::op_t op, input int n);
        send_item(op, {POS_ZERO, NEG_ZERO, POS_ZERO}, {NEG_ZERO, POS_ZERO, NEG_ZERO});
        send_item(op, {ONE, ONE, ONE}, {ONE, NEG_ONE, ONE});
        send_item(op, {NEG_ONE, NEG_TWO_HALF, NEG_ONE}, {NEG_TWO_HALF, NEG_ONE, POS_ZERO});
        for (int i = 0; i < n; i++) begin
            send_item(op, rand_vec(), rand_vec());
        end
    endtask

    task automatic wait_outputs(input int target, input int max_cycles);
        int waited;
        waited = 0;
        while (outputs_seen < target && waited < max_cycles) begin
            next_cycle();
            waited = waited + 1;
        end
    endtask

    task automatic wait_drain(input int max_cycles);
        int waited;
        waited = 0;
        while (sb.size() != 0 && waited < max_cycles) begin
            next_cycle();
            waited = waited + 1;
        end
    endtask

    task automatic check_output();
        logic [95:0] exp;
        if (sb.size() == 0) begin
            report_failure("out_valid seen with no result expected");
        end else begin
            exp = sb.pop_front();
            outputs_seen = outputs_seen + 1;
            assert ({out_x, out_y, out_z} == exp) else
                report_failure($sformatf("result %0d is %h %h %h, expected %h %h %h",
                    outputs_seen, out_x, out_y, out_z,
                    exp[95:64], exp[63:32], exp[31:0]));
        end
    endtask

    // outputs only move on rising edges, so the falling edge sees them settled
    always @(negedge clk_in) begin
        if (in_credit) begin
            credits_returned = credits_returned + 1;
        end
        if (out_valid) begin
            check_output();
        end
    end

    // downstream credits, manual grants first
    initial begin
        out_credit = 1'b0;
        forever begin
            next_cycle();
            if (credits_given < manual_credits) begin
                out_credit    = 1'b1;
                credits_given = credits_given + 1;
            end else if (credit_random) begin
                out_credit = (($random(seed) & 3) != 0);
            end else begin
                out_credit = 1'b0;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure("watchdog timeout, the run did not finish in time");
    end

    initial begin
        int base;
        int r;
        vec_pkg::op_t op;
        rst_in   = 1'b1;
        in_valid = 1'b0;
        in_op    = vec_pkg::OP_MAX;
        in_a_x   = '0;
        in_a_y   = '0;
        in_a_z   = '0;
        in_b_x   = '0;
        in_b_y   = '0;
        in_b_z   = '0;
        repeat (4) @(posedge clk_in);
        #1;
        rst_in = 1'b0;

        // quiet after reset
        idle_cycles(8);
        assert (credits_returned == 0) else
            report_failure("in_credit pulsed before any input was given");

        // back-pressure, fill the queue with no downstream credit
        base = outputs_seen;
        for (int i = 0; i < DEPTH; i++) begin
            send_item(vec_pkg::OP_PMIN, rand_vec(), rand_vec());
        end
        idle_cycles(12);
        assert (outputs_seen == base) else
            report_failure("a result came out without a downstream credit");
        assert (available_credits() == 0) else
            report_failure("upstream credits were returned while the queue was blocked");
        for (int i = 0; i < DEPTH; i++) begin
            manual_credits = manual_credits + 1;
            wait_outputs(base + i + 1, 20);
            idle_cycles(3);
            assert (outputs_seen == base + i + 1) else
                report_failure("one downstream credit did not give exactly one result");
        end

        credit_random = 1'b1;
        run_op(vec_pkg::OP_MAX, N_DIRECTED);
        run_op(vec_pkg::OP_MIN, N_DIRECTED);
        run_op(vec_pkg::OP_PMIN, N_DIRECTED);

        // mixed stream at full rate
        for (int i = 0; i < N_MIXED; i++) begin
            r = $random(seed);
            case ($unsigned(r) % 3)
                0:       op = vec_pkg::OP_MAX;
                1:       op = vec_pkg::OP_MIN;
                default: op = vec_pkg::OP_PMIN;
            endcase
            send_item(op, rand_vec(), rand_vec());
        end

        wait_drain(400);
        idle_cycles(4);
        if (sb.size() != 0) begin
            report_failure($sformatf("%0d results never came out", sb.size()));
        end else if (credits_returned != credits_spent) begin
            report_failure($sformatf("%0d in_credit pulses for %0d items",
                credits_returned, credits_spent));
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tb/vec_minmax_props.sv
`timescale 1ns/1ps
`default_nettype none

module vec_minmax_props #(
    parameter int FIFO_DEPTH = 4,
    parameter int CNT_W      = 3
) (
    input wire logic             clk_in,
    input wire logic             rst_in,
    input wire logic             res_valid,
    input wire logic             out_credit,
    input wire logic             out_valid,
    input wire logic             in_credit,
    input wire logic [CNT_W-1:0] count
);

    localparam logic [CNT_W-1:0] FULL = CNT_W'(FIFO_DEPTH);

    // downstream credits granted and not yet spent
    int granted;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            granted <= 0;
        end else begin
            granted <= granted + int'(out_credit) - int'(out_valid);
        end
    end

    // upstream credits must keep a free slot for every item in flight
    no_write_when_full: assert property (
        @(posedge clk_in) disable iff (rst_in)
        res_valid |-> (count != FULL)
    ) else $error("result written into a full queue");

    pop_needs_credit: assert property (
        @(posedge clk_in) disable iff (rst_in)
        out_valid |-> (granted > 0)
    ) else $error("out_valid with no downstream credit");

    credit_with_pop: assert property (
        @(posedge clk_in) disable iff (rst_in)
        in_credit == out_valid
    ) else $error("in_credit and out_valid differ");

    quiet_in_reset: assert property (
        @(posedge clk_in)
        rst_in |=> (!out_valid && !in_credit)
    ) else $error("out_valid or in_credit high after a reset cycle");

endmodule

bind result_queue vec_minmax_props #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .CNT_W      (CNT_W)
) props_i (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .res_valid  (res_valid),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .in_credit  (in_credit),
    .count      (count)
);

`default_nettype wire

//--- rtl/vec_minmax_top.sv
`timescale 1ns/1ps
`default_nettype none

module vec_minmax_top #(
    parameter int FIFO_DEPTH = vec_pkg::DEFAULT_FIFO_DEPTH
) (
    input  wire logic            clk_in,
    input  wire logic            rst_in,
    input  wire logic            in_valid,
    input  wire vec_pkg::op_t    in_op,
    input  wire vec_pkg::float_t in_a_x,
    input  wire vec_pkg::float_t in_a_y,
    input  wire vec_pkg::float_t in_a_z,
    input  wire vec_pkg::float_t in_b_x,
    input  wire vec_pkg::float_t in_b_y,
    input  wire vec_pkg::float_t in_b_z,
    output logic                 in_credit,
    input  wire logic            out_credit,
    output logic                 out_valid,
    output vec_pkg::float_t      out_x,
    output vec_pkg::float_t      out_y,
    output vec_pkg::float_t      out_z
);

    logic            res_valid;
    vec_pkg::float_t res_x;
    vec_pkg::float_t res_y;
    vec_pkg::float_t res_z;

    vec_stage_if stage_if ();

    vec_compare compare_i (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .in_valid (in_valid),
        .in_op    (in_op),
        .in_a_x   (in_a_x),
        .in_a_y   (in_a_y),
        .in_a_z   (in_a_z),
        .in_b_x   (in_b_x),
        .in_b_y   (in_b_y),
        .in_b_z   (in_b_z),
        .stage    (stage_if.src)
    );

    vec_select select_i (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .stage     (stage_if.dst),
        .res_valid (res_valid),
        .res_x     (res_x),
        .res_y     (res_y),
        .res_z     (res_z)
    );

    result_queue #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) queue_i (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .res_valid  (res_valid),
        .res_x      (res_x),
        .res_y      (res_y),
        .res_z      (res_z),
        .in_credit  (in_credit),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_x      (out_x),
        .out_y      (out_y),
        .out_z      (out_z)
    );

endmodule

`default_nettype wire

//--- rtl/result_queue.sv
`timescale 1ns/1ps
`default_nettype none

module result_queue #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic            clk_in,
    input  wire logic            rst_in,
    input  wire logic            res_valid,
    input  wire vec_pkg::float_t res_x,
    input  wire vec_pkg::float_t res_y,
    input  wire vec_pkg::float_t res_z,
    output logic                 in_credit,
    input  wire logic            out_credit,
    output logic                 out_valid,
    output vec_pkg::float_t      out_x,
    output vec_pkg::float_t      out_y,
    output vec_pkg::float_t      out_z
);

    localparam int PTR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
    // room for credits granted well ahead of results
    localparam int CRED_W = $clog2(FIFO_DEPTH + 1) + 3;

    vec_pkg::float_t mem_x [FIFO_DEPTH];
    vec_pkg::float_t mem_y [FIFO_DEPTH];
    vec_pkg::float_t mem_z [FIFO_DEPTH];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [CRED_W-1:0] credits;
    logic              pop;

    // head leaves as soon as a downstream credit is held
    assign pop       = (count != '0) && (credits != '0);
    assign out_valid = pop;
    assign in_credit = pop;
    assign out_x     = mem_x[rd_ptr];
    assign out_y     = mem_y[rd_ptr];
    assign out_z     = mem_z[rd_ptr];

    always_ff @(posedge clk_in) begin
        if (res_valid) begin
            mem_x[wr_ptr] <= res_x;
            mem_y[wr_ptr] <= res_y;
            mem_z[wr_ptr] <= res_z;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= '0;
        end else begin
            if (res_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end

            case ({res_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // saturate rather than wrap
            case ({out_credit, pop})
                2'b10: begin
                    if (!(&credits)) begin
                        credits <= credits + 1'b1;
                    end
                end
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/vec_select.sv
`timescale 1ns/1ps
`default_nettype none

module vec_select (
    input  wire logic       clk_in,
    input  wire logic       rst_in,
    vec_stage_if.dst        stage,
    output logic            res_valid,
    output vec_pkg::float_t res_x,
    output vec_pkg::float_t res_y,
    output vec_pkg::float_t res_z
);

    vec_pkg::float_t next_x;
    vec_pkg::float_t next_y;
    vec_pkg::float_t next_z;

    always_comb begin
        next_x = '0;
        next_y = '0;
        next_z = '0;
        case (stage.op)
            vec_pkg::OP_MAX, vec_pkg::OP_MIN: begin
                // same pick for both, flags already oriented
                if (stage.flags[1] && stage.flags[2]) begin
                    next_x = stage.a_z;
                end else if (stage.flags[0]) begin
                    next_x = stage.a_x;
                end else begin
                    next_x = stage.a_y;
                end
            end
            vec_pkg::OP_PMIN: begin
                next_x = stage.flags[0] ? stage.a_x : stage.b_x;
                next_y = stage.flags[1] ? stage.a_y : stage.b_y;
                next_z = stage.flags[2] ? stage.a_z : stage.b_z;
            end
            default: begin
                // unused code gives zeros
            end
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= stage.valid;
        end
    end

    always_ff @(posedge clk_in) begin
        res_x <= next_x;
        res_y <= next_y;
        res_z <= next_z;
    end

endmodule

`default_nettype wire

//--- rtl/vec_compare.sv
`timescale 1ns/1ps
`default_nettype none

module vec_compare (
    input  wire logic            clk_in,
    input  wire logic            rst_in,
    input  wire logic            in_valid,
    input  wire vec_pkg::op_t    in_op,
    input  wire vec_pkg::float_t in_a_x,
    input  wire vec_pkg::float_t in_a_y,
    input  wire vec_pkg::float_t in_a_z,
    input  wire vec_pkg::float_t in_b_x,
    input  wire vec_pkg::float_t in_b_y,
    input  wire vec_pkg::float_t in_b_z,
    vec_stage_if.src             stage
);

    vec_pkg::float_t lhs_0;
    vec_pkg::float_t rhs_0;
    vec_pkg::float_t lhs_1;
    vec_pkg::float_t rhs_1;
    vec_pkg::float_t lhs_2;
    vec_pkg::float_t rhs_2;
    vec_pkg::cmp_flags_t flags;

    // operand pairs per opcode
    always_comb begin
        case (in_op)
            vec_pkg::OP_MAX: begin
                lhs_0 = in_a_y;
                rhs_0 = in_a_x;
                lhs_1 = in_a_y;
                rhs_1 = in_a_z;
                lhs_2 = in_a_x;
                rhs_2 = in_a_z;
            end
            vec_pkg::OP_MIN: begin
                lhs_0 = in_a_x;
                rhs_0 = in_a_y;
                lhs_1 = in_a_z;
                rhs_1 = in_a_y;
                lhs_2 = in_a_z;
                rhs_2 = in_a_x;
            end
            default: begin
                // component-wise a against b
                lhs_0 = in_a_x;
                rhs_0 = in_b_x;
                lhs_1 = in_a_y;
                rhs_1 = in_b_y;
                lhs_2 = in_a_z;
                rhs_2 = in_b_z;
            end
        endcase
    end

    assign flags = {vec_pkg::float_lt(lhs_2, rhs_2),
                    vec_pkg::float_lt(lhs_1, rhs_1),
                    vec_pkg::float_lt(lhs_0, rhs_0)};

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            stage.valid <= 1'b0;
        end else begin
            stage.valid <= in_valid;
        end
    end

    // payload, no reset needed
    always_ff @(posedge clk_in) begin
        stage.op    <= in_op;
        stage.flags <= flags;
        stage.a_x   <= in_a_x;
        stage.a_y   <= in_a_y;
        stage.a_z   <= in_a_z;
        stage.b_x   <= in_b_x;
        stage.b_y   <= in_b_y;
        stage.b_z   <= in_b_z;
    end

endmodule

`default_nettype wire

//--- rtl/vec_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

interface vec_stage_if;

    logic                valid;
    vec_pkg::op_t        op;
    vec_pkg::cmp_flags_t flags;
    vec_pkg::float_t     a_x;
    vec_pkg::float_t     a_y;
    vec_pkg::float_t     a_z;
    vec_pkg::float_t     b_x;
    vec_pkg::float_t     b_y;
    vec_pkg::float_t     b_z;

    modport src (
        output valid, op, flags,
        output a_x, a_y, a_z, b_x, b_y, b_z
    );

    modport dst (
        input valid, op, flags,
        input a_x, a_y, a_z, b_x, b_y, b_z
    );

endinterface

`default_nettype wire

//--- rtl/vec_pkg.sv
`default_nettype none

package vec_pkg;

    // one single-precision value
    typedef logic [31:0] float_t;

    typedef logic [1:0] op_t;

    // c0..c2 from the compare stage
    typedef logic [2:0] cmp_flags_t;

    localparam op_t OP_MAX  = 2'd0;
    localparam op_t OP_MIN  = 2'd1;
    localparam op_t OP_PMIN = 2'd2;

    localparam int DEFAULT_FIFO_DEPTH = 4;

    // strict a < b, NaN not handled, +0 and -0 equal
    function automatic logic float_lt(input float_t a, input float_t b);
        logic both_zero;
        logic lt;
        both_zero = (a[30:0] == 31'd0) && (b[30:0] == 31'd0);
        if (a[31] != b[31]) begin
            lt = a[31] && !both_zero;
        end else if (!a[31]) begin
            lt = a[30:0] < b[30:0];
        end else begin
            // negative side, larger magnitude is smaller
            lt = a[30:0] > b[30:0];
        end
        return lt;
    endfunction

endpackage

`default_nettype wire
